//--- common/pov_pkg.sv
package pov_pkg;

    // Display geometry, one driver column holds 16 LEDs and is multiplexed 8 times
    localparam int multiplexing = 8;
    localparam int led_per_driver = 16;
    localparam int buff_size = 240;
    localparam int buff_size_log = 8;
    localparam int row_size = 40;
    localparam int column_size = 48;
    localparam int image_size = 1920;
    localparam int slices_in_ram = 3;
    localparam int ram_words = 5760;
    localparam int ram_addr_width = 13;
    localparam int ram_data_width = 16;

    // Driver stream timing
    localparam int poker_mode = 9;
    localparam int driver_count = 30;
    localparam int config_cycles = 16;
    localparam int frame_beats = 432;
    localparam int blank_cycles = 8;

    // Bit offset of each colour inside a memory word, indexed by colour
    localparam logic [3:0] color_base [3] = '{0, 6, 11};

    // Buffer base index per driver, drivers of a facing pair share one entry
    localparam logic [buff_size_log-1:0] driver_base [driver_count] = '{
        0, 0, 1, 1, 2, 2, 3, 3, 4, 4,
        80, 80, 81, 81, 82, 82, 83, 83, 84, 84,
        160, 160, 161, 161, 162, 162, 163, 163, 164, 164
    };

    // Per LED offsets in the buffer, neighbouring LEDs of a driver sit 5 words apart
    // Group 0 covers drivers 20 to 29
    localparam logic [buff_size_log-1:0] lut0_rg [led_per_driver] = '{
        30, 35, 45, 40, 50, 55, 65, 60, 70, 75, 5, 0, 10, 15, 25, 20
    };
    localparam logic [buff_size_log-1:0] lut0_b [led_per_driver] = '{
        40, 45, 70, 75, 60, 65, 10, 15, 0, 5, 30, 35, 20, 25, 50, 55
    };
    // Group 1 covers drivers 0 to 19
    localparam logic [buff_size_log-1:0] lut1_rg [led_per_driver] = '{
        10, 15, 25, 20, 30, 35, 45, 40, 50, 55, 65, 60, 70, 75, 5, 0
    };
    localparam logic [buff_size_log-1:0] lut1_b [led_per_driver] = '{
        0, 5, 30, 35, 20, 25, 45, 55, 40, 50, 70, 75, 60, 65, 10, 15
    };

    // Colours go out in this order for every LED
    typedef enum logic [1:0] {color_blue, color_red, color_green} color_e;

    typedef enum logic {fb_wait_slice, fb_stream} fb_state_e;

    typedef enum logic [1:0] {drv_config, drv_frame, drv_blank} drv_state_e;

    // One host write, the handshake valid travels next to it
    typedef struct packed {
        logic [ram_addr_width-1:0] addr;
        logic [ram_data_width-1:0] data;
    } host_wr_t;

    // Serial outputs towards the LED drivers
    typedef struct packed {
        logic [driver_count-1:0] sdi;
        // High on every valid beat
        logic clk_en;
        // One cycle pulse after the last beat of a frame
        logic lat;
        logic blank;
    } led_out_t;

endpackage

//--- slice_ram/slice_ram.sv
`timescale 1ns/10ps

// Slice storage for all 3 slices, one 15-bit colour word per address
module slice_ram (
    input  logic                                clk_33,
    input  logic                                wr_en,
    input  pov_pkg::host_wr_t                   wr,
    input  logic [pov_pkg::ram_addr_width-1:0]  rd_addr,
    output logic [pov_pkg::ram_data_width-1:0]  rd_data
);

    // Slice s occupies addresses s*1920 up to s*1920+1919
    logic [pov_pkg::ram_data_width-1:0] mem [pov_pkg::ram_words];

    // Writes beyond the last slice are dropped
    always_ff @(posedge clk_33) begin
        if (wr_en && (wr.addr < pov_pkg::ram_addr_width'(pov_pkg::ram_words))) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // The framebuffer fills one buffer word per cycle
    // So the read data has to come back in the same cycle
    assign rd_data = mem[rd_addr];

endmodule

//--- slice_ram/slice_loader.sv
`timescale 1ns/10ps

module slice_loader (
    input  logic              clk_33,
    input  logic              nrst,
    input  logic              host_valid,
    output logic              host_ready,
    input  pov_pkg::host_wr_t host_wr,
    output logic              wr_en,
    output pov_pkg::host_wr_t wr,
    output logic              stream_ready
);

    // One flag per word of slice 0, set on the first write to that word
    logic [pov_pkg::image_size-1:0] written;
    // Number of distinct slice 0 words stored so far
    logic [$clog2(pov_pkg::image_size+1)-1:0] fill_cnt;
    // Position of the write inside slice 0
    logic [$clog2(pov_pkg::image_size)-1:0] slot;
    logic first_hit;

    // A write transfers when both sides agree, it lands in memory at the same edge
    assign wr_en = host_valid && host_ready;
    assign wr = host_wr;

    assign slot = host_wr.addr[$clog2(pov_pkg::image_size)-1:0];
    // Rewrites of an already stored word must not count again
    assign first_hit = wr_en
                    && (host_wr.addr < pov_pkg::ram_addr_width'(pov_pkg::image_size))
                    && !written[slot];

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            host_ready <= 1'b0;
            written <= '0;
            fill_cnt <= '0;
        end else begin
            // Ready comes up one cycle after reset and then stays
            host_ready <= 1'b1;
            if (first_hit) begin
                written[slot] <= 1'b1;
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // The counter saturates on its own since every flag is then set
    assign stream_ready = (fill_cnt == ($bits(fill_cnt))'(pov_pkg::image_size));

endmodule

//--- framebuffer/framebuffer.sv
`timescale 1ns/10ps

module framebuffer (
    input  logic                                clk_33,
    input  logic                                nrst,
    input  logic                                stream_ready,
    input  logic                                driver_ready,
    input  logic                                position_sync,
    output logic                                stream_active,
    output logic [pov_pkg::driver_count-1:0]    data,
    output logic [pov_pkg::ram_addr_width-1:0]  ram_addr,
    input  logic [pov_pkg::ram_data_width-1:0]  ram_data
);

    // Two column buffers, column c of any slice always lives in buffer c[0]
    // This works because a slice has an even number of columns
    logic [pov_pkg::ram_data_width-1:0] col_buf [2][pov_pkg::buff_size];

    // Fill side, the column and slice being loaded and the word index
    logic [pov_pkg::buff_size_log-1:0] fill_idx;
    logic [$clog2(pov_pkg::multiplexing)-1:0] fill_col;
    logic [$clog2(pov_pkg::slices_in_ram)-1:0] slice_cnt;
    logic [pov_pkg::ram_addr_width-1:0] slice_base;
    logic fill_done;
    logic fill_start;

    // Stream side counters, from the innermost to the outermost
    pov_pkg::fb_state_e state;
    pov_pkg::color_e rgb;
    logic [$clog2(pov_pkg::led_per_driver)-1:0] led_idx;
    logic [$clog2(pov_pkg::poker_mode)-1:0] bit_idx;
    logic [$clog2(pov_pkg::multiplexing)-1:0] col_idx;

    logic beat;
    logic sync_accept;
    logic column_last;
    // Registered end of columns 0 to 6, each one triggers the next fill
    logic col_done;

    // Selection of one bit per driver
    logic [pov_pkg::buff_size_log-1:0] voxel_idx [pov_pkg::driver_count];
    logic [3:0] color_addr;
    logic [pov_pkg::driver_count-1:0] sel_bits;

    assign stream_active = (state == pov_pkg::fb_stream);
    assign beat = driver_ready && stream_active;
    assign fill_done = (fill_idx == pov_pkg::buff_size_log'(pov_pkg::buff_size));

    // A slice may only start once column 0 sits complete in its buffer
    assign sync_accept = position_sync && stream_ready && fill_done
                      && (state == pov_pkg::fb_wait_slice);

    // Column 1 loads during column 0, column c+2 loads after column c is sent
    // After column 6 this wraps into column 0 of the next slice
    assign fill_start = sync_accept || col_done;

    assign slice_base = pov_pkg::ram_addr_width'(slice_cnt * pov_pkg::image_size);
    // Word j of a buffer holds column fill_col of driver column j, 8 words apart in memory
    assign ram_addr = slice_base + pov_pkg::ram_addr_width'(fill_col)
                    + pov_pkg::ram_addr_width'({fill_idx, 3'b000});

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            // Reset leaves a pending fill of column 0 of slice 0
            fill_idx <= '0;
            fill_col <= '0;
            slice_cnt <= '0;
        end else if (fill_start) begin
            fill_idx <= '0;
            fill_col <= fill_col + 1'b1;
            if (fill_col == ($bits(fill_col))'(pov_pkg::multiplexing - 1)) begin
                slice_cnt <= (slice_cnt == ($bits(slice_cnt))'(pov_pkg::slices_in_ram - 1))
                           ? '0 : slice_cnt + 1'b1;
            end
        end else if (stream_ready && !fill_done) begin
            fill_idx <= fill_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_33) begin
        if (stream_ready && !fill_done) begin
            col_buf[fill_col[0]][fill_idx] <= ram_data;
        end
    end

    // True on the beat that sends green of LED 0 at bit 0, the end of a column
    assign column_last = (rgb == pov_pkg::color_green) && (led_idx == '0) && (bit_idx == '0);

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            state <= pov_pkg::fb_wait_slice;
            rgb <= pov_pkg::color_blue;
            led_idx <= ($bits(led_idx))'(pov_pkg::led_per_driver - 1);
            bit_idx <= ($bits(bit_idx))'(pov_pkg::poker_mode - 1);
            col_idx <= '0;
            col_done <= 1'b0;
        end else begin
            col_done <= beat && column_last
                     && (col_idx != ($bits(col_idx))'(pov_pkg::multiplexing - 1));
            if (sync_accept) begin
                state <= pov_pkg::fb_stream;
            end else if (beat) begin
                if (rgb != pov_pkg::color_green) begin
                    rgb <= pov_pkg::color_e'(rgb + 2'd1);
                end else begin
                    rgb <= pov_pkg::color_blue;
                    led_idx <= led_idx - 1'b1;
                    // All LEDs have had this bit, move on to the next lower bit
                    if (led_idx == '0) begin
                        bit_idx <= bit_idx - 1'b1;
                        if (bit_idx == '0) begin
                            bit_idx <= ($bits(bit_idx))'(pov_pkg::poker_mode - 1);
                            // Counter wraps to column 0 after the last column
                            col_idx <= col_idx + 1'b1;
                            if (col_idx == ($bits(col_idx))'(pov_pkg::multiplexing - 1)) begin
                                state <= pov_pkg::fb_wait_slice;
                            end
                        end
                    end
                end
            end
        end
    end

    // bit_idx 8 down to 4 maps onto the colour MSB down to LSB
    assign color_addr = pov_pkg::color_base[rgb] + 4'(bit_idx - 4'd4);

    always_comb begin
        for (int i = 0; i < pov_pkg::driver_count; i++) begin
            // Blue LEDs are wired in another order than red and green
            if (i < 20) begin
                voxel_idx[i] = pov_pkg::driver_base[i]
                             + ((rgb == pov_pkg::color_blue) ? pov_pkg::lut1_b[led_idx]
                                                             : pov_pkg::lut1_rg[led_idx]);
            end else begin
                voxel_idx[i] = pov_pkg::driver_base[i]
                             + ((rgb == pov_pkg::color_blue) ? pov_pkg::lut0_b[led_idx]
                                                             : pov_pkg::lut0_rg[led_idx]);
            end
            sel_bits[i] = col_buf[col_idx[0]][voxel_idx[i]][color_addr];
        end
    end

    // Bits 3 to 0 of the poker sequence pad with zero, and so does a cycle without a beat
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            data <= '0;
        end else if (beat && (bit_idx > 4'd3)) begin
            data <= sel_bits;
        end else begin
            data <= '0;
        end
    end

endmodule

//--- driver/driver_main_controller.sv
`timescale 1ns/10ps

module driver_main_controller (
    input  logic                             clk_33,
    input  logic                             nrst,
    input  logic                             stream_active,
    input  logic [pov_pkg::driver_count-1:0] data,
    output logic                             driver_ready,
    output pov_pkg::led_out_t                led
);

    pov_pkg::drv_state_e state;
    // Beats already sent in the current frame
    logic [$clog2(pov_pkg::frame_beats)-1:0] beat_cnt;
    // Counts the configuration phase and then each blanking gap
    logic [$clog2(pov_pkg::config_cycles)-1:0] gap_cnt;
    logic gap_done;
    logic frame_start;
    logic last_beat;
    // Delay line that lines the control bits up with the framebuffer data
    logic ready_d1;
    logic last_d1;
    logic last_d2;

    assign gap_done = (gap_cnt == ($bits(gap_cnt))'(pov_pkg::blank_cycles));
    // The first beat of a frame already goes out in the cycle the stream is seen
    assign frame_start = (state == pov_pkg::drv_blank) && gap_done && stream_active;
    assign driver_ready = (state == pov_pkg::drv_frame) || frame_start;
    assign last_beat = (state == pov_pkg::drv_frame)
                    && (beat_cnt == ($bits(beat_cnt))'(pov_pkg::frame_beats - 1));

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            state <= pov_pkg::drv_config;
            beat_cnt <= '0;
            gap_cnt <= '0;
        end else begin
            case (state)
                pov_pkg::drv_config: begin
                    // No gap is owed after configuration, so the counter starts expired
                    if (gap_cnt == ($bits(gap_cnt))'(pov_pkg::config_cycles - 1)) begin
                        state <= pov_pkg::drv_blank;
                        gap_cnt <= ($bits(gap_cnt))'(pov_pkg::blank_cycles);
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                pov_pkg::drv_blank: begin
                    if (frame_start) begin
                        state <= pov_pkg::drv_frame;
                        beat_cnt <= ($bits(beat_cnt))'(1);
                    end else if (!gap_done) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                pov_pkg::drv_frame: begin
                    if (last_beat) begin
                        state <= pov_pkg::drv_blank;
                        beat_cnt <= '0;
                        gap_cnt <= '0;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: state <= pov_pkg::drv_config;
            endcase
        end
    end

    // Data arrives one cycle after its beat, so sdi and clk_en both land two cycles late
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            ready_d1 <= 1'b0;
            last_d1 <= 1'b0;
            last_d2 <= 1'b0;
            led.sdi <= '0;
            led.clk_en <= 1'b0;
            led.lat <= 1'b0;
            led.blank <= 1'b1;
        end else begin
            ready_d1 <= driver_ready;
            last_d1 <= last_beat;
            last_d2 <= last_d1;
            led.sdi <= data;
            led.clk_en <= ready_d1;
            // Latch follows the clk_en of the last beat by one cycle
            led.lat <= last_d2;
            led.blank <= !ready_d1;
        end
    end

endmodule

//--- verilog/pov_top.sv
`timescale 1ns/10ps

module pov_top (
    input  logic              clk_33,
    input  logic              nrst,
    input  logic              host_valid,
    output logic              host_ready,
    input  pov_pkg::host_wr_t host_wr,
    input  logic              position_sync,
    output pov_pkg::led_out_t led
);

    // Host side write into the slice memory
    logic wr_en;
    pov_pkg::host_wr_t wr;
    // Slice 0 complete, the framebuffer may start filling
    logic stream_ready;

    // Framebuffer read port
    logic [pov_pkg::ram_addr_width-1:0] ram_addr;
    logic [pov_pkg::ram_data_width-1:0] ram_data;

    // Handshake between framebuffer and driver controller
    logic stream_active;
    logic driver_ready;
    logic [pov_pkg::driver_count-1:0] data;

    slice_loader i_slice_loader (
        .clk_33(clk_33), .nrst(nrst),
        .host_valid(host_valid), .host_ready(host_ready), .host_wr(host_wr),
        .wr_en(wr_en), .wr(wr), .stream_ready(stream_ready)
    );

    slice_ram i_slice_ram (
        .clk_33(clk_33), .wr_en(wr_en), .wr(wr),
        .rd_addr(ram_addr), .rd_data(ram_data)
    );

    framebuffer i_framebuffer (
        .clk_33(clk_33), .nrst(nrst),
        .stream_ready(stream_ready), .driver_ready(driver_ready),
        .position_sync(position_sync), .stream_active(stream_active),
        .data(data), .ram_addr(ram_addr), .ram_data(ram_data)
    );

    driver_main_controller i_driver_main_controller (
        .clk_33(clk_33), .nrst(nrst),
        .stream_active(stream_active), .data(data),
        .driver_ready(driver_ready), .led(led)
    );

endmodule

//--- bench/pov_tb_assert.sv
`timescale 1ns/10ps

// Framebuffer properties, bound into every framebuffer instance
module pov_fb_assert (
    input logic                                clk_33,
    input logic                                nrst,
    input logic                                stream_ready,
    input logic                                driver_ready,
    input logic                                stream_active,
    input logic [pov_pkg::driver_count-1:0]    data,
    input logic [pov_pkg::buff_size_log-1:0]   fill_idx
);

    // A cycle without a beat leaves the data bus at zero one cycle later
    no_beat_zero_data: assert property (@(posedge clk_33) disable iff (!nrst)
        !(driver_ready && stream_active) |=> (data == '0))
        else $error("framebuffer data not zero after a cycle without a beat");

    // The fill index stops at the buffer size and never runs past it
    fill_idx_in_range: assert property (@(posedge clk_33) disable iff (!nrst)
        fill_idx <= pov_pkg::buff_size_log'(pov_pkg::buff_size))
        else $error("framebuffer fill index beyond the buffer size");

    // Streaming needs slice 0 to be complete in memory
    stream_after_ready: assert property (@(posedge clk_33) disable iff (!nrst)
        $rose(stream_active) |-> stream_ready)
        else $error("framebuffer stream started before stream_ready");

endmodule

bind framebuffer pov_fb_assert i_pov_fb_assert (
    .clk_33(clk_33),
    .nrst(nrst),
    .stream_ready(stream_ready),
    .driver_ready(driver_ready),
    .stream_active(stream_active),
    .data(data),
    .fill_idx(fill_idx)
);

//--- bench/pov_tb.sv
`timescale 1ns/10ps

module pov_tb;

    localparam int clk_period = 8;
    // One frame and its blanking gap, eight of them make a slice
    localparam int slice_cycles = pov_pkg::multiplexing
                                * (pov_pkg::frame_beats + pov_pkg::blank_cycles);
    localparam int slice_beats = pov_pkg::multiplexing * pov_pkg::frame_beats;
    // Beats spent on one poker bit, three colours for each LED
    localparam int beats_per_bit = pov_pkg::led_per_driver * 3;
    // Four slices are streamed and loading costs at most two cycles per word
    localparam int watchdog_cycles = 4 * slice_cycles + 2 * pov_pkg::ram_words + 4000;

    logic clk_33;
    logic nrst;
    logic host_valid;
    logic host_ready;
    pov_pkg::host_wr_t host_wr;
    logic position_sync;
    pov_pkg::led_out_t led;

    // Copy of every word the DUT accepted from the host
    logic [pov_pkg::ram_data_width-1:0] mirror [pov_pkg::ram_words];
    int seed;
    int errors;
    int lat_cnt;
    int frame_beat_cnt;
    logic prev_clk_en;
    logic sync_given;

    pov_top i_pov_top (
        .clk_33(clk_33),
        .nrst(nrst),
        .host_valid(host_valid),
        .host_ready(host_ready),
        .host_wr(host_wr),
        .position_sync(position_sync),
        .led(led)
    );

    always #(clk_period / 2) clk_33 = ~clk_33;

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        errors++;
        $display("Fail %s got %h expected %h", name, got, exp);
    endtask

    // Expected sdi of one beat, taken from the mirror with the poker order rules
    function automatic logic [pov_pkg::driver_count-1:0] expected_sdi(input int slice,
        input int col, input int bit_pos, input int led_pos, input int color);
        logic [pov_pkg::driver_count-1:0] v;
        int offset;
        int word_addr;
        logic [pov_pkg::ram_data_width-1:0] word;
        v = '0;
        // The four lowest poker bits carry no colour
        if (bit_pos > 3) begin
            for (int i = 0; i < pov_pkg::driver_count; i++) begin
                // Drivers 0 to 19 sit in LUT group 1, blue LEDs have their own order
                if (i < 20) begin
                    offset = (color == int'(pov_pkg::color_blue))
                           ? int'(pov_pkg::lut1_b[led_pos]) : int'(pov_pkg::lut1_rg[led_pos]);
                end else begin
                    offset = (color == int'(pov_pkg::color_blue))
                           ? int'(pov_pkg::lut0_b[led_pos]) : int'(pov_pkg::lut0_rg[led_pos]);
                end
                word_addr = slice * pov_pkg::image_size + col
                          + pov_pkg::multiplexing * (int'(pov_pkg::driver_base[i]) + offset);
                word = mirror[word_addr];
                v[i] = word[int'(pov_pkg::color_base[color]) + bit_pos - 4];
            end
        end
        return v;
    endfunction

    // Frame structure on the LED outputs, sampled away from the rising edge
    always @(negedge clk_33) begin
        if (nrst) begin
            if (led.clk_en && !sync_given) begin
                errors++;
                $display("clk_en came out before any position_sync");
            end
            if (led.blank !== !led.clk_en)
                value_error("led.blank", 32'(led.blank), 32'(!led.clk_en));
            if (prev_clk_en && !led.clk_en && !led.lat) begin
                errors++;
                $display("clk_en dropped inside a frame without a latch pulse");
            end
            if (led.clk_en)
                frame_beat_cnt++;
            if (led.lat) begin
                if (frame_beat_cnt != pov_pkg::frame_beats)
                    value_error("beats per frame", frame_beat_cnt, pov_pkg::frame_beats);
                frame_beat_cnt = 0;
                lat_cnt++;
            end
            prev_clk_en = led.clk_en;
        end
    end

    task automatic check_reset();
        if (led.clk_en !== 1'b0)
            value_error("led.clk_en", 32'(led.clk_en), 0);
        if (led.lat !== 1'b0)
            value_error("led.lat", 32'(led.lat), 0);
        if (led.blank !== 1'b1)
            value_error("led.blank", 32'(led.blank), 1);
        if (led.sdi !== '0)
            value_error("led.sdi", 32'(led.sdi), 0);
        // Ready stays low until the first edge after reset release
        if (host_ready !== 1'b0)
            value_error("host_ready", 32'(host_ready), 0);
        @(negedge clk_33);
        if (host_ready !== 1'b1)
            value_error("host_ready", 32'(host_ready), 1);
    endtask

    // Holds one write on the bus until ready is seen, the word lands at the next rising edge
    task automatic write_word(input int addr, input logic [pov_pkg::ram_data_width-1:0] wdata);
        int waited;
        @(negedge clk_33);
        host_valid = 1'b1;
        host_wr.addr = pov_pkg::ram_addr_width'(addr);
        host_wr.data = wdata;
        waited = 0;
        while (host_ready !== 1'b1 && waited < 8) begin
            @(negedge clk_33);
            waited++;
        end
        if (host_ready !== 1'b1) begin
            errors++;
            $display("host_ready stayed low, write to address %h was never taken", addr);
        end else begin
            mirror[addr] = wdata;
        end
    endtask

    task automatic load_slices();
        for (int addr = 0; addr < pov_pkg::ram_words; addr++) begin
            // Now and then an idle cycle with valid low and junk aimed at the word before
            if (($random(seed) & 3) == 0) begin
                @(negedge clk_33);
                host_valid = 1'b0;
                host_wr.addr = pov_pkg::ram_addr_width'((addr > 0) ? addr - 1 : addr);
                host_wr.data = pov_pkg::ram_data_width'($random(seed));
            end
            write_word(addr, pov_pkg::ram_data_width'($random(seed)));
        end
        @(negedge clk_33);
        host_valid = 1'b0;
    endtask

    // Inverted words with valid low, any of them landing shows up in the slice 0 check
    // The output monitor flags any beat during this wait
    task automatic check_no_stream();
        int addr;
        for (int n = 0; n < 2 * pov_pkg::buff_size; n++) begin
            @(negedge clk_33);
            addr = (n * 7) % pov_pkg::image_size;
            host_valid = 1'b0;
            host_wr.addr = pov_pkg::ram_addr_width'(addr);
            host_wr.data = ~mirror[addr];
        end
    endtask

    task automatic wait_clk_en(input int limit, output logic seen);
        int n;
        n = 0;
        while (led.clk_en !== 1'b1 && n < limit) begin
            @(negedge clk_33);
            n++;
        end
        seen = (led.clk_en === 1'b1);
    endtask

    task automatic run_slice(input int slice, input int check_beats);
        logic seen;
        int r;
        int n;
        logic [pov_pkg::driver_count-1:0] exp;
        @(negedge clk_33);
        sync_given = 1'b1;
        position_sync = 1'b1;
        @(negedge clk_33);
        wait_clk_en(64, seen);
        position_sync = 1'b0;
        if (!seen) begin
            errors++;
            $display("No beat came out after position_sync for slice %0d", slice);
            return;
        end
        for (int k = 0; k < slice_beats; k++) begin
            if (k > 0) begin
                @(negedge clk_33);
                wait_clk_en(2 * pov_pkg::blank_cycles + 8, seen);
                if (!seen) begin
                    errors++;
                    $display("Slice %0d stream stopped after %0d beats", slice, k);
                    return;
                end
            end
            if (k < check_beats) begin
                // Beat k splits into column, bit, LED and colour in sending order
                r = k % pov_pkg::frame_beats;
                exp = expected_sdi(slice, k / pov_pkg::frame_beats,
                                   pov_pkg::poker_mode - 1 - r / beats_per_bit,
                                   pov_pkg::led_per_driver - 1 - (r % beats_per_bit) / 3,
                                   (r % beats_per_bit) % 3);
                if (led.sdi !== exp)
                    value_error($sformatf("led.sdi slice %0d beat %0d", slice, k),
                                32'(led.sdi), 32'(exp));
            end
        end
        // The latch pulse closes the last frame of the slice
        n = 0;
        @(negedge clk_33);
        while (led.lat !== 1'b1 && n < 4) begin
            @(negedge clk_33);
            n++;
        end
        if (led.lat !== 1'b1) begin
            errors++;
            $display("No latch pulse after the last frame of slice %0d", slice);
        end
    endtask

    initial begin
        clk_33 = 1'b0;
        nrst = 1'b0;
        host_valid = 1'b0;
        host_wr = '0;
        position_sync = 1'b0;
        seed = 6345;
        errors = 0;
        lat_cnt = 0;
        frame_beat_cnt = 0;
        prev_clk_en = 1'b0;
        sync_given = 1'b0;
        repeat (2) @(negedge clk_33);
        nrst = 1'b1;
        check_reset();
        load_slices();
        check_no_stream();
        // Slice 0 in full, then slices 1 and 2 and slice 0 again after the wrap
        run_slice(0, slice_beats);
        run_slice(1, pov_pkg::frame_beats);
        run_slice(2, pov_pkg::frame_beats);
        run_slice(0, pov_pkg::frame_beats);
        repeat (4) @(negedge clk_33);
        if (lat_cnt != 4 * pov_pkg::multiplexing)
            value_error("lat pulse count", lat_cnt, 4 * pov_pkg::multiplexing);
        $display("Simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired, the DUT did not finish the tests in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- flist.f
common/pov_pkg.sv
slice_ram/slice_ram.sv
slice_ram/slice_loader.sv
framebuffer/framebuffer.sv
driver/driver_main_controller.sv
verilog/pov_top.sv
bench/pov_tb_assert.sv
bench/pov_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides on the log contents

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pov_tb -f flist.f -o pov_sim \
    && ./obj_dir/pov_sim | tee sim.log \
    && grep -qF '*** TEST PASSED ***' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
